// ==== verilog/icache_pkg.sv ====
package icache_pkg;

    // ------------------------------------------------------------------
    // bus widths
    // ------------------------------------------------------------------

    localparam int ADDR_W = 32;   // fetch and memory byte address
    localparam int WORD_W = 32;   // instruction / memory data word

    // ------------------------------------------------------------------
    // refill controller states
    // ------------------------------------------------------------------

    // idle     waiting for a registered miss
    // request  mem_valid up, no beat accepted yet
    // burst    streaming the remaining beats of the line
    // done     line complete, commit tag and valid bit
    typedef enum logic [1:0] {
        idle    = 2'd0,
        request = 2'd1,
        burst   = 2'd2,
        done    = 2'd3
    } refill_state_t;

endpackage

// ==== verilog/icache_request.sv ====
`timescale 1ns/100ps

module icache_request #(
    parameter int WAYS      = 2,
    parameter int SET_BITS  = 4,
    parameter int LINE_BITS = 4,
    localparam int TAG_W     = icache_pkg::ADDR_W - SET_BITS - LINE_BITS,
    localparam int WORD_BITS = LINE_BITS - 2
) (
    input  logic                          clock,
    input  logic                          reset,

    input  logic                          fetch_valid,
    input  logic [icache_pkg::ADDR_W-1:0] fetch_addr,
    input  logic                          fetch_ready,

    output logic                          req_active,
    output logic [icache_pkg::ADDR_W-1:0] req_addr,
    output logic [TAG_W-1:0]              req_tag,
    output logic [SET_BITS-1:0]           req_set,
    output logic [WORD_BITS-1:0]          req_word,

    input  logic                          refill_done,
    output logic [WAYS-1:0]               req_victim
);

    localparam int SETS = 1 << SET_BITS;

    logic [WAYS-1:0] victim_ptr [SETS];  // one-hot, one per set
    logic [WAYS-1:0] cur_ptr;

    // address fields of the held request
    assign req_tag  = req_addr[icache_pkg::ADDR_W-1 -: TAG_W];
    assign req_set  = req_addr[LINE_BITS +: SET_BITS];
    assign req_word = req_addr[2 +: WORD_BITS];

    assign cur_ptr    = victim_ptr[req_set];
    assign req_victim = cur_ptr;

    // ------------------------------------------------------------------
    // request hold
    // ------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            req_active <= 1'b0;
        end else if (req_active && fetch_ready) begin
            req_active <= 1'b0;       // answered, free next cycle
        end else if (!req_active && fetch_valid) begin
            req_active <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!req_active && fetch_valid) begin
            req_addr <= fetch_addr;   // held until the ready pulse
        end
    end

    // round-robin victim pointer, rotates once per installed line
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < SETS; s++) begin
                victim_ptr[s] <= WAYS'(1);
            end
        end else if (refill_done) begin
            victim_ptr[req_set] <= (cur_ptr << 1) | (cur_ptr >> (WAYS - 1));
        end
    end

endmodule

// ==== verilog/icache_way.sv ====
`timescale 1ns/100ps

module icache_way #(
    parameter int SET_BITS  = 4,
    parameter int LINE_BITS = 4,
    localparam int TAG_W     = icache_pkg::ADDR_W - SET_BITS - LINE_BITS,
    localparam int WORD_BITS = LINE_BITS - 2
) (
    input  logic                          clock,
    input  logic                          reset,

    // lookup
    input  logic [TAG_W-1:0]              req_tag,
    input  logic [SET_BITS-1:0]           req_set,
    input  logic [WORD_BITS-1:0]          req_word,
    output logic                          way_hit,
    output logic [icache_pkg::WORD_W-1:0] way_data,

    // line fill
    input  logic                          fill_en,
    input  logic                          fill_sel,
    input  logic [WORD_BITS-1:0]          fill_word,
    input  logic [icache_pkg::WORD_W-1:0] fill_data,
    input  logic                          fill_commit
);

    localparam int SETS  = 1 << SET_BITS;
    localparam int WORDS = 1 << WORD_BITS;

    logic [TAG_W-1:0]              tag_mem  [SETS];
    logic [icache_pkg::WORD_W-1:0] data_mem [SETS*WORDS];
    logic [SETS-1:0]               valid;

    logic [SET_BITS+WORD_BITS-1:0] rd_index;
    logic [SET_BITS+WORD_BITS-1:0] wr_index;
    logic                          line_write;
    logic                          line_commit;

    assign rd_index    = {req_set, req_word};
    assign wr_index    = {req_set, fill_word};
    assign line_write  = fill_en & fill_sel;
    assign line_commit = fill_commit & fill_sel;

    // ------------------------------------------------------------------
    // valid bits and registered tag compare
    // ------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            valid   <= '0;
            way_hit <= 1'b0;
        end else begin
            way_hit <= valid[req_set] && (tag_mem[req_set] == req_tag);
            if (line_commit) begin
                valid[req_set] <= 1'b1;
            end else if (line_write) begin
                // a half-written line never looks valid
                valid[req_set] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (line_commit) begin
            tag_mem[req_set] <= req_tag;
        end
    end

    // word array, one read port and one fill port
    always_ff @(posedge clock) begin
        if (line_write) begin
            data_mem[wr_index] <= fill_data;
        end
        way_data <= data_mem[rd_index];
    end

endmodule

// ==== verilog/icache_hit_select.sv ====
`timescale 1ns/100ps

module icache_hit_select #(
    parameter int WAYS = 2
) (
    input  logic                               clock,
    input  logic                               reset,

    input  logic                               req_active,
    input  logic [WAYS-1:0]                    way_hit,
    input  logic [WAYS*icache_pkg::WORD_W-1:0] way_data,

    input  logic                               refill_done,
    input  logic                               refill_error,
    output logic                               lookup_hit,

    output logic                               fetch_ready,
    output logic [icache_pkg::WORD_W-1:0]      fetch_data,
    output logic                               fetch_error
);

    logic [icache_pkg::WORD_W-1:0] hit_word;
    logic                          req_q;      // way_hit belongs to the held request
    logic                          answered;   // one pulse per request
    logic                          respond;

    // at most one way hits, so OR of masked words is the select
    always_comb begin
        hit_word = '0;
        for (int i = 0; i < WAYS; i++) begin
            if (way_hit[i]) begin
                hit_word = hit_word | way_data[i*icache_pkg::WORD_W +: icache_pkg::WORD_W];
            end
        end
    end

    assign lookup_hit = |way_hit;

    // refill_done itself does not answer, the reread of the new line does
    assign respond = req_active && !answered && !refill_done &&
                     ((req_q && lookup_hit) || refill_error);

    always_ff @(posedge clock) begin
        if (reset) begin
            req_q       <= 1'b0;
            answered    <= 1'b0;
            fetch_ready <= 1'b0;
            fetch_error <= 1'b0;
        end else begin
            req_q       <= req_active;
            fetch_ready <= respond;
            fetch_error <= respond && refill_error;
            if (!req_active) begin
                answered <= 1'b0;
            end else if (respond) begin
                answered <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (respond) begin
            fetch_data <= refill_error ? '0 : hit_word;   // zero on bus error
        end
    end

endmodule

// ==== verilog/icache_refill.sv ====
`timescale 1ns/100ps

module icache_refill #(
    parameter int WAYS      = 2,
    parameter int LINE_BITS = 4,
    localparam int WORD_BITS = LINE_BITS - 2
) (
    input  logic                          clock,
    input  logic                          reset,

    // lookup side
    input  logic                          req_active,
    input  logic                          lookup_hit,
    input  logic [icache_pkg::ADDR_W-1:0] req_addr,
    input  logic [WAYS-1:0]               req_victim,

    // memory burst port
    output logic                          mem_valid,
    output logic [icache_pkg::ADDR_W-1:0] mem_addr,
    output logic [7:0]                    mem_len,
    input  logic                          mem_ready,
    input  logic [icache_pkg::WORD_W-1:0] mem_data,
    input  logic                          mem_err,

    // fill toward the ways
    output logic                          fill_en,
    output logic [WAYS-1:0]               fill_way,
    output logic [WORD_BITS-1:0]          fill_word,
    output logic [icache_pkg::WORD_W-1:0] fill_data,
    output logic                          fill_commit,

    output logic                          refill_done,
    output logic                          refill_error
);

    localparam int WORDS = 1 << WORD_BITS;

    icache_pkg::refill_state_t state;

    logic [WORD_BITS-1:0] beat;       // index of the next word expected
    logic                 req_q;      // lookup result is for the held request
    logic                 served;     // refill already finished for it
    logic                 start;
    logic                 beat_take;
    logic                 last_beat;

    assign mem_len   = 8'(WORDS - 1);
    assign mem_valid = (state == icache_pkg::request) || (state == icache_pkg::burst);

    assign start     = (state == icache_pkg::idle) && req_active && req_q &&
                       !lookup_hit && !served;
    assign beat_take = mem_valid && mem_ready;
    assign last_beat = ({{(8-WORD_BITS){1'b0}}, beat} == mem_len);

    // beats go straight through to the victim way
    assign fill_en     = beat_take && !mem_err;
    assign fill_word   = beat;
    assign fill_data   = mem_data;
    assign fill_commit = (state == icache_pkg::done);

    // ------------------------------------------------------------------
    // refill FSM
    // ------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            state        <= icache_pkg::idle;
            beat         <= '0;
            fill_way     <= '0;
            req_q        <= 1'b0;
            served       <= 1'b0;
            refill_done  <= 1'b0;
            refill_error <= 1'b0;
        end else begin
            req_q        <= req_active;
            refill_done  <= 1'b0;
            refill_error <= 1'b0;
            if (!req_active) begin
                served <= 1'b0;
            end
            case (state)
                icache_pkg::idle: begin
                    if (start) begin
                        state    <= icache_pkg::request;
                        beat     <= '0;
                        fill_way <= req_victim;   // victim fixed for the whole line
                    end
                end
                icache_pkg::request, icache_pkg::burst: begin
                    if (beat_take) begin
                        if (mem_err) begin
                            state        <= icache_pkg::idle;   // abort, no commit
                            refill_error <= 1'b1;
                            served       <= 1'b1;
                        end else if (last_beat) begin
                            state <= icache_pkg::done;
                        end else begin
                            state <= icache_pkg::burst;
                            beat  <= beat + 1'b1;
                        end
                    end
                end
                icache_pkg::done: begin
                    state       <= icache_pkg::idle;
                    refill_done <= 1'b1;
                    served      <= 1'b1;
                end
                default: state <= icache_pkg::idle;
            endcase
        end
    end

    // line-aligned burst address
    always_ff @(posedge clock) begin
        if (start) begin
            mem_addr <= {req_addr[icache_pkg::ADDR_W-1:LINE_BITS], {LINE_BITS{1'b0}}};
        end
    end

endmodule

// ==== verilog/icache_top.sv ====
`timescale 1ns/100ps

module icache_top #(
    parameter int WAYS      = 2,
    parameter int SET_BITS  = 4,
    parameter int LINE_BITS = 4
) (
    input  logic                          clock,
    input  logic                          reset,

    // fetch port
    input  logic                          fetch_valid,
    input  logic [icache_pkg::ADDR_W-1:0] fetch_addr,
    output logic                          fetch_ready,
    output logic [icache_pkg::WORD_W-1:0] fetch_data,
    output logic                          fetch_error,

    // memory burst port
    output logic                          mem_valid,
    output logic [icache_pkg::ADDR_W-1:0] mem_addr,
    output logic [7:0]                    mem_len,
    input  logic                          mem_ready,
    input  logic [icache_pkg::WORD_W-1:0] mem_data,
    input  logic                          mem_err
);

    localparam int TAG_W     = icache_pkg::ADDR_W - SET_BITS - LINE_BITS;
    localparam int WORD_BITS = LINE_BITS - 2;

    logic                               req_active;
    logic [icache_pkg::ADDR_W-1:0]      req_addr;
    logic [TAG_W-1:0]                   req_tag;
    logic [SET_BITS-1:0]                req_set;
    logic [WORD_BITS-1:0]               req_word;
    logic [WAYS-1:0]                    req_victim;

    logic [WAYS-1:0]                    way_hit;
    logic [WAYS*icache_pkg::WORD_W-1:0] way_data;
    logic                               lookup_hit;

    logic                               fill_en;
    logic [WAYS-1:0]                    fill_way;
    logic [WORD_BITS-1:0]               fill_word;
    logic [icache_pkg::WORD_W-1:0]      fill_data;
    logic                               fill_commit;
    logic                               refill_done;
    logic                               refill_error;

    icache_request #(
        .WAYS(WAYS), .SET_BITS(SET_BITS), .LINE_BITS(LINE_BITS)
    ) u_request (
        .clock(clock), .reset(reset),
        .fetch_valid(fetch_valid), .fetch_addr(fetch_addr), .fetch_ready(fetch_ready),
        .req_active(req_active), .req_addr(req_addr),
        .req_tag(req_tag), .req_set(req_set), .req_word(req_word),
        .refill_done(refill_done), .req_victim(req_victim)
    );

    // ------------------------------------------------------------------
    // way banks
    // ------------------------------------------------------------------

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        icache_way #(
            .SET_BITS(SET_BITS), .LINE_BITS(LINE_BITS)
        ) u_way (
            .clock(clock), .reset(reset),
            .req_tag(req_tag), .req_set(req_set), .req_word(req_word),
            .way_hit(way_hit[w]),
            .way_data(way_data[w*icache_pkg::WORD_W +: icache_pkg::WORD_W]),
            .fill_en(fill_en), .fill_sel(fill_way[w]),   // one-hot victim
            .fill_word(fill_word), .fill_data(fill_data), .fill_commit(fill_commit)
        );
    end

    icache_hit_select #(
        .WAYS(WAYS)
    ) u_hit_select (
        .clock(clock), .reset(reset),
        .req_active(req_active), .way_hit(way_hit), .way_data(way_data),
        .refill_done(refill_done), .refill_error(refill_error), .lookup_hit(lookup_hit),
        .fetch_ready(fetch_ready), .fetch_data(fetch_data), .fetch_error(fetch_error)
    );

    icache_refill #(
        .WAYS(WAYS), .LINE_BITS(LINE_BITS)
    ) u_refill (
        .clock(clock), .reset(reset),
        .req_active(req_active), .lookup_hit(lookup_hit),
        .req_addr(req_addr), .req_victim(req_victim),
        .mem_valid(mem_valid), .mem_addr(mem_addr), .mem_len(mem_len),
        .mem_ready(mem_ready), .mem_data(mem_data), .mem_err(mem_err),
        .fill_en(fill_en), .fill_way(fill_way), .fill_word(fill_word),
        .fill_data(fill_data), .fill_commit(fill_commit),
        .refill_done(refill_done), .refill_error(refill_error)
    );

endmodule

// ==== test/icache_assertions.sv ====
`timescale 1ns/100ps

module icache_assertions (
    input logic                      clock,
    input logic                      reset,
    input icache_pkg::refill_state_t state,
    input logic                      mem_valid,
    input logic                      mem_ready,
    input logic                      mem_err,
    input logic                      last_beat,
    input logic                      fill_commit,
    input logic                      refill_done,
    input logic                      refill_error
);

    int failures = 0;   // failed assertion count

    // ------------------------------------------------------------------
    // burst handshake
    // ------------------------------------------------------------------

    // mem_valid drops only after the last beat or an error beat
    valid_hold: assert property (@(posedge clock) disable iff (reset)
        $past(mem_valid && !(mem_ready && (last_beat || mem_err))) |-> mem_valid)
    else begin
        $error("mem_valid dropped before the last beat of the burst");
        failures++;
    end

    stall_hold: assert property (@(posedge clock) disable iff (reset)
        $past(state == icache_pkg::burst && !mem_ready) |-> state == icache_pkg::burst)
    else begin
        $error("refill left the burst state during a memory stall");
        failures++;
    end

    // ------------------------------------------------------------------
    // refill completion
    // ------------------------------------------------------------------

    no_commit_on_error: assert property (@(posedge clock) disable iff (reset)
        !(fill_commit && refill_error))
    else begin
        $error("fill_commit together with refill_error");
        failures++;
    end

    done_pulse: assert property (@(posedge clock) disable iff (reset)
        $past(refill_done) |-> !refill_done)
    else begin
        $error("refill_done high for more than one cycle");
        failures++;
    end

endmodule

bind icache_refill icache_assertions u_assertions (
    .clock(clock), .reset(reset), .state(state),
    .mem_valid(mem_valid), .mem_ready(mem_ready), .mem_err(mem_err),
    .last_beat(last_beat), .fill_commit(fill_commit),
    .refill_done(refill_done), .refill_error(refill_error)
);

// ==== test/icache_tb.sv ====
`timescale 1ns/100ps

module icache_tb;

    localparam int WAYS       = 2;
    localparam int SET_BITS   = 4;
    localparam int LINE_BITS  = 4;
    localparam int SETS       = 1 << SET_BITS;
    localparam int LINE_BYTES = 1 << LINE_BITS;
    localparam int WORDS      = LINE_BYTES / 4;
    localparam int MAX_FETCH  = 128;

    localparam logic [31:0] WORD_KEY = 32'hA5C3_0000;   // memory word = address ^ key
    localparam logic [31:0] BAD_BASE = 32'h0000_F000;
    localparam logic [31:0] BAD_LAST = 32'h0000_FFFF;
    localparam logic [31:0] NO_ENTRY = 32'hFFFF_FFFF;   // never a word address

    logic                          clock = 1'b0;
    logic                          reset;
    logic                          fetch_valid;
    logic [icache_pkg::ADDR_W-1:0] fetch_addr;
    logic                          fetch_ready;
    logic [icache_pkg::WORD_W-1:0] fetch_data;
    logic                          fetch_error;
    logic                          mem_valid;
    logic [icache_pkg::ADDR_W-1:0] mem_addr;
    logic [7:0]                    mem_len;
    logic                          mem_ready;
    logic [icache_pkg::WORD_W-1:0] mem_data;
    logic                          mem_err;

    logic [31:0] pattern_mem [3*MAX_FETCH];   // address, word, error flag
    int          num_patterns = 0;
    bit          loaded = 1'b0;
    int          errors = 0;
    int          assert_fails;
    integer      seed = 64;
    int          burst_count = 0;
    int          ready_pulses = 0;
    logic [31:0] last_burst_addr;

    // reference contents of the cache, line addresses per set and way
    logic [31:0] model_line  [SETS][WAYS];
    bit          model_valid [SETS][WAYS];
    int          model_ptr   [SETS];

    always #10 clock = ~clock;

    icache_top #(
        .WAYS(WAYS), .SET_BITS(SET_BITS), .LINE_BITS(LINE_BITS)
    ) uut (
        .clock(clock), .reset(reset),
        .fetch_valid(fetch_valid), .fetch_addr(fetch_addr), .fetch_ready(fetch_ready),
        .fetch_data(fetch_data), .fetch_error(fetch_error),
        .mem_valid(mem_valid), .mem_addr(mem_addr), .mem_len(mem_len),
        .mem_ready(mem_ready), .mem_data(mem_data), .mem_err(mem_err)
    );

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got %h, expected %h at %0t", name, actual, expected, $time);
            errors++;
        end
    endtask

    function automatic bit in_bad_region(input logic [31:0] addr);
        return (addr >= BAD_BASE) && (addr <= BAD_LAST);
    endfunction

    // ------------------------------------------------------------------
    // burst memory model
    // ------------------------------------------------------------------

    initial begin : memory_model
        int   beat;
        logic accept;
        logic err_seen;
        logic valid_before;
        beat         = 0;
        valid_before = 1'b0;
        mem_ready    = 1'b0;
        mem_data     = '0;
        mem_err      = 1'b0;
        forever begin
            @(negedge clock);
            accept   = mem_valid && mem_ready;   // beat taken at the coming edge
            err_seen = mem_err;
            if (mem_valid && !valid_before) begin
                burst_count++;
                last_burst_addr = mem_addr;
                compare_value("mem_addr offset", mem_addr & 32'(LINE_BYTES - 1), 32'd0);
                compare_value("mem_len", 32'(mem_len), 32'(WORDS - 1));
            end
            valid_before = mem_valid;
            @(posedge clock);
            #1;
            if (accept) begin
                if (err_seen || beat == WORDS - 1) begin
                    beat = 0;
                end else begin
                    beat++;
                end
            end
            mem_ready = ($random(seed) & 3) != 0;   // roughly one stall in four
            mem_data  = mem_valid ? ((mem_addr + 32'(beat * 4)) ^ WORD_KEY) : '0;
            mem_err   = mem_valid && in_bad_region(mem_addr);
        end
    end

    always @(negedge clock) begin
        if (fetch_ready) begin
            ready_pulses++;
        end
    end

    // one fetch, checked against the address rules and the reference contents
    task automatic run_fetch(input logic [31:0] addr, input logic [31:0] file_word,
                             input logic [31:0] file_err);
        logic [31:0] line;
        logic [31:0] exp_word;
        logic        exp_err;
        bit          exp_hit;
        int          set;
        int          cycles;
        int          bursts_before;
        int          pulses_before;

        line     = addr & ~32'(LINE_BYTES - 1);
        set      = int'(addr[LINE_BITS +: SET_BITS]);
        exp_err  = in_bad_region(addr);
        exp_word = exp_err ? 32'd0 : (addr ^ WORD_KEY);
        exp_hit  = 1'b0;
        for (int w = 0; w < WAYS; w++) begin
            if (model_valid[set][w] && model_line[set][w] == line) begin
                exp_hit = 1'b1;
            end
        end
        compare_value("pattern word", file_word, exp_word);
        compare_value("pattern error flag", file_err, 32'(exp_err));

        bursts_before = burst_count;
        pulses_before = ready_pulses;
        fetch_addr    = addr;
        fetch_valid   = 1'b1;
        cycles        = 0;
        do begin
            @(posedge clock);
            #1;
            cycles++;
        end while (!fetch_ready);
        fetch_valid = 1'b0;
        compare_value("fetch_data", fetch_data, exp_word);
        compare_value("fetch_error", 32'(fetch_error), 32'(exp_err));
        if (exp_hit) begin
            compare_value("hit latency", 32'(cycles - 1), 32'd2);   // edges after sampling
        end

        @(posedge clock);
        #1;
        compare_value("fetch_ready after pulse", 32'(fetch_ready), 32'd0);
        compare_value("fetch_ready pulses", 32'(ready_pulses - pulses_before), 32'd1);
        compare_value("burst count", 32'(burst_count - bursts_before),
                      exp_hit ? 32'd0 : 32'd1);
        if (!exp_hit) begin
            compare_value("mem_addr", last_burst_addr, line);
            if (!exp_err) begin
                // installed in the round-robin victim way
                model_line[set][model_ptr[set]]  = line;
                model_valid[set][model_ptr[set]] = 1'b1;
                model_ptr[set] = (model_ptr[set] + 1) % WAYS;
            end
        end
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------

    initial begin : stimulus
        fetch_valid = 1'b0;
        fetch_addr  = '0;
        reset       = 1'b1;
        for (int i = 0; i < 3 * MAX_FETCH; i++) begin
            pattern_mem[i] = NO_ENTRY;
        end
        $readmemh("test/icache_patterns.hex", pattern_mem);
        while (num_patterns < MAX_FETCH && pattern_mem[3 * num_patterns] !== NO_ENTRY) begin
            num_patterns++;
        end
        loaded = 1'b1;
        if (num_patterns == 0) begin
            $display("No fetch patterns were read from test/icache_patterns.hex");
            errors++;
        end

        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;
        compare_value("fetch_ready", 32'(fetch_ready), 32'd0);
        compare_value("mem_valid", 32'(mem_valid), 32'd0);
        compare_value("fill_en", 32'(uut.fill_en), 32'd0);
        compare_value("fill_commit", 32'(uut.fill_commit), 32'd0);

        for (int n = 0; n < num_patterns; n++) begin
            run_fetch(pattern_mem[3*n], pattern_mem[3*n + 1], pattern_mem[3*n + 2]);
        end

        assert_fails = uut.u_refill.u_assertions.failures;
        $display("Done: %0d fetches, %0d bursts, %0d check errors, %0d assertion failures",
                 num_patterns, burst_count, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        wait (loaded);
        repeat ((num_patterns + 1) * 200) @(posedge clock);
        $display("Timeout: the fetch sequence did not finish within %0d cycles",
                 (num_patterns + 1) * 200);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== test/icache_patterns.hex ====
// fetch address, expected instruction word, expected bus error flag
// a bus error returns a zero word
00001000 A5C31000 0
00001000 A5C31000 0
00001004 A5C31004 0
00001008 A5C31008 0
0000100C A5C3100C 0
00002030 A5C32030 0
00003034 A5C33034 0
00002038 A5C32038 0
0000303C A5C3303C 0
00004030 A5C34030 0
00003030 A5C33030 0
00002034 A5C32034 0
00004038 A5C34038 0
0000303C A5C3303C 0
00002030 A5C32030 0
0000F000 00000000 1
0000F004 00000000 1
0000FF80 00000000 1
00000100 A5C30100 0
00000204 A5C30204 0
00000108 A5C30108 0
0000020C A5C3020C 0
00000300 A5C30300 0
00000104 A5C30104 0
00010040 A5C20040 0
00010044 A5C20044 0
12345678 B7F75678 0
1234567C B7F7567C 0
80000070 25C30070 0
80000074 25C30074 0
00001000 A5C31000 0
00000F00 A5C30F00 0
0000FFFC 00000000 1
00002030 A5C32030 0
00004030 A5C34030 0
0000F010 00000000 1
00000F0C A5C30F0C 0
00001008 A5C31008 0

// ==== tb.f ====
verilog/icache_pkg.sv
verilog/icache_request.sv
verilog/icache_way.sv
verilog/icache_hit_select.sv
verilog/icache_refill.sv
verilog/icache_top.sv
test/icache_assertions.sv
test/icache_tb.sv

// ==== Makefile ====
# Verilator build of the instruction cache testbench

TOP = icache_tb
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -Mdir $(OBJ)

# the run fails unless the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ)/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf $(OBJ)
